// File: axi_sub/axi_sub.sv
// AXI subordinate to simplex request bridge
`default_nettype none

module axi_sub (
    input  logic           clk,
    input  logic           rst_n,
    // Write address and data
    input  logic           awvalid,
    output logic           awready,
    input  mci_pkg::addr_t awaddr,
    input  mci_pkg::id_t   awid,
    input  mci_pkg::user_t awuser,
    input  logic [7:0]     awlen,
    input  logic           wvalid,
    output logic           wready,
    input  mci_pkg::data_t wdata,
    input  mci_pkg::strb_t wstrb,
    // Write response
    output logic           bvalid,
    input  logic           bready,
    output mci_pkg::resp_t bresp,
    output mci_pkg::id_t   bid,
    // Read address
    input  logic           arvalid,
    output logic           arready,
    input  mci_pkg::addr_t araddr,
    input  mci_pkg::id_t   arid,
    input  mci_pkg::user_t aruser,
    input  logic [7:0]     arlen,
    // Read data
    output logic           rvalid,
    input  logic           rready,
    output mci_pkg::data_t rdata,
    output mci_pkg::resp_t rresp,
    output mci_pkg::id_t   rid,
    output logic           rlast,
    // Internal request
    cif_if.request         soc_req
);
    import mci_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wr_req,
        st_rd_req,
        st_wr_resp,
        st_rd_resp
    } state_e;

    state_e state_q;
    logic   aw_take;
    logic   ar_take;
    logic   req_done;

    // Captured request
    addr_t  addr_q;
    user_t  user_q;
    id_t    id_q;
    data_t  wdata_q;
    strb_t  wstrb_q;

    // Captured response
    resp_t  resp_q;
    data_t  rdata_q;

    // Write wins when both directions arrive together
    assign aw_take  = (state_q == st_idle) && awvalid && wvalid;
    assign ar_take  = (state_q == st_idle) && arvalid && !(awvalid && wvalid);
    assign req_done = soc_req.dv && !soc_req.hold;

    assign awready = aw_take;
    assign wready  = aw_take;
    assign arready = ar_take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (aw_take) begin
                        state_q <= st_wr_req;
                    end else if (ar_take) begin
                        state_q <= st_rd_req;
                    end
                end
                st_wr_req: begin
                    if (req_done) state_q <= st_wr_resp;
                end
                st_rd_req: begin
                    if (req_done) state_q <= st_rd_resp;
                end
                // Hold the response until the manager takes it
                st_wr_resp: begin
                    if (bready) state_q <= st_idle;
                end
                st_rd_resp: begin
                    if (rready) state_q <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Address phase capture
    always_ff @(posedge clk) begin
        if (aw_take) begin
            addr_q  <= awaddr;
            user_q  <= awuser;
            id_q    <= awid;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (ar_take) begin
            addr_q  <= araddr;
            user_q  <= aruser;
            id_q    <= arid;
            wdata_q <= '0;
            wstrb_q <= '0;
        end
        // Latch target response on completion
        if (req_done) begin
            resp_q  <= soc_req.error ? resp_slverr : resp_okay;
            rdata_q <= soc_req.rdata;
        end
    end

    // One request on the internal bus
    assign soc_req.dv    = (state_q == st_wr_req) || (state_q == st_rd_req);
    assign soc_req.write = (state_q == st_wr_req);
    assign soc_req.addr  = addr_q;
    assign soc_req.wdata = wdata_q;
    assign soc_req.wstrb = wstrb_q;
    assign soc_req.user  = user_q;
    assign soc_req.id    = id_q;

    assign bvalid = (state_q == st_wr_resp);
    assign bresp  = resp_q;
    assign bid    = id_q;

    assign rvalid = (state_q == st_rd_resp);
    assign rdata  = rdata_q;
    assign rresp  = resp_q;
    assign rid    = id_q;
    assign rlast  = 1'b1;

    // Single beat only
    a_awlen_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (awvalid && awready) |-> (awlen == 8'd0));
    a_arlen_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && arready) |-> (arlen == 8'd0));
    // B channel and its payload stay up until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp) && $stable(bid)));

endmodule

`default_nettype wire

// File: common/cif_if.sv
// Internal simplex request bus
`default_nettype none

interface cif_if;
    import mci_pkg::*;

    // Request side
    logic  dv;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    user_t user;
    id_t   id;

    // Response side, valid in the completion cycle
    logic  hold;
    data_t rdata;
    logic  error;

    modport request (
        output dv, write, addr, wdata, wstrb, user, id,
        input  hold, rdata, error
    );

    modport response (
        input  dv, write, addr, wdata, wstrb, user, id,
        output hold, rdata, error
    );

endinterface

`default_nettype wire

// File: common/mci_pkg.sv
// MCI AXI front end shared definitions
`default_nettype none

package mci_pkg;

    // Bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [31:0] user_t;
    typedef logic [7:0]  id_t;
    typedef logic [1:0]  resp_t;

    // AXI response codes
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // Register window
    localparam addr_t regs_base  = 32'h0000_0000;
    localparam int unsigned regs_words = 16;
    localparam addr_t regs_mask  = addr_t'(regs_words * 4 - 1);
    typedef logic [$clog2(regs_words)-1:0] reg_idx_t;

    // MCU SRAM window, 4 KB
    localparam addr_t sram_base  = 32'h0020_0000;
    localparam int unsigned sram_words = 1024;
    localparam addr_t sram_mask  = addr_t'(sram_words * 4 - 1);
    typedef logic [$clog2(sram_words)-1:0] sram_idx_t;

    // Register offsets and constants
    localparam addr_t reg_id_off         = 32'h0;
    localparam addr_t reg_soc_config_off = 32'h4;
    localparam data_t mci_id_value       = 32'h4d43_4900;

    // Byte lanes with strobe set take the new data
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: filelist.f
common/mci_pkg.sv
common/cif_if.sv
axi_sub/axi_sub.sv
src/mci_axi_sub_decode.sv
src/mci_regs.sv
src/mcu_sram.sv
src/mci_axi_sub_top.sv
verif/tb_clk_gen.sv
verif/mci_axi_sub_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
    --top-module mci_axi_sub_tb -o mci_axi_sub_sim
out=$(./obj_dir/mci_axi_sub_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1

// File: src/mci_axi_sub_decode.sv
// Request decode and privilege straps
`default_nettype none

module mci_axi_sub_decode (
    input  logic           clk,
    input  logic           rst_n,
    cif_if.response        soc_req,
    cif_if.request         regs_req,
    cif_if.request         sram_req,
    output logic           soc_config_priv,
    // Privileged request levels
    output logic           axi_mci_soc_config_req,
    output logic           axi_mcu_lsu_req,
    output logic           axi_mcu_ifu_req,
    output logic           axi_mcu_req,
    output logic           axi_mcu_sram_config_req,
    // Privileged users
    input  mci_pkg::user_t strap_mci_soc_config_axi_user,
    input  mci_pkg::user_t strap_mcu_lsu_axi_user,
    input  mci_pkg::user_t strap_mcu_ifu_axi_user,
    input  mci_pkg::user_t strap_mcu_sram_config_axi_user
);
    import mci_pkg::*;

    logic regs_hit;
    logic sram_hit;

    // Both windows are size aligned
    assign regs_hit = (soc_req.addr & ~regs_mask) == regs_base;
    assign sram_hit = (soc_req.addr & ~sram_mask) == sram_base;

    // dv only to the selected target
    assign regs_req.dv = soc_req.dv && regs_hit;
    assign sram_req.dv = soc_req.dv && sram_hit;

    // Fields fan out to both
    assign regs_req.write = soc_req.write;
    assign regs_req.addr  = soc_req.addr;
    assign regs_req.wdata = soc_req.wdata;
    assign regs_req.wstrb = soc_req.wstrb;
    assign regs_req.user  = soc_req.user;
    assign regs_req.id    = soc_req.id;

    assign sram_req.write = soc_req.write;
    assign sram_req.addr  = soc_req.addr;
    assign sram_req.wdata = soc_req.wdata;
    assign sram_req.wstrb = soc_req.wstrb;
    assign sram_req.user  = soc_req.user;
    assign sram_req.id    = soc_req.id;

    // Response merge
    always_comb begin
        if (regs_hit) begin
            soc_req.hold  = regs_req.hold;
            soc_req.rdata = regs_req.rdata;
            soc_req.error = regs_req.error;
        end else if (sram_hit) begin
            soc_req.hold  = sram_req.hold;
            soc_req.rdata = sram_req.rdata;
            soc_req.error = sram_req.error;
        end else begin
            // Unmapped, complete at once with error
            soc_req.hold  = 1'b0;
            soc_req.rdata = '0;
            soc_req.error = 1'b1;
        end
    end

    // Strap compares, levels only while dv
    assign axi_mci_soc_config_req  = soc_req.dv && (soc_req.user == strap_mci_soc_config_axi_user);
    assign axi_mcu_lsu_req         = soc_req.dv && (soc_req.user == strap_mcu_lsu_axi_user);
    assign axi_mcu_ifu_req         = soc_req.dv && (soc_req.user == strap_mcu_ifu_axi_user);
    assign axi_mcu_sram_config_req = soc_req.dv &&
                                     (soc_req.user == strap_mcu_sram_config_axi_user);
    assign axi_mcu_req             = axi_mcu_lsu_req || axi_mcu_ifu_req;

    // Register block reuses this compare
    assign soc_config_priv = axi_mci_soc_config_req;

    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({regs_req.dv, sram_req.dv}));

endmodule

`default_nettype wire

// File: src/mci_axi_sub_top.sv
// MCI AXI subordinate top
`default_nettype none

module mci_axi_sub_top (
    input  logic           clk,
    input  logic           rst_n,
    // AXI write
    input  logic           awvalid,
    output logic           awready,
    input  mci_pkg::addr_t awaddr,
    input  mci_pkg::id_t   awid,
    input  mci_pkg::user_t awuser,
    input  logic [7:0]     awlen,
    input  logic           wvalid,
    output logic           wready,
    input  mci_pkg::data_t wdata,
    input  mci_pkg::strb_t wstrb,
    output logic           bvalid,
    input  logic           bready,
    output mci_pkg::resp_t bresp,
    output mci_pkg::id_t   bid,
    // AXI read
    input  logic           arvalid,
    output logic           arready,
    input  mci_pkg::addr_t araddr,
    input  mci_pkg::id_t   arid,
    input  mci_pkg::user_t aruser,
    input  logic [7:0]     arlen,
    output logic           rvalid,
    input  logic           rready,
    output mci_pkg::data_t rdata,
    output mci_pkg::resp_t rresp,
    output mci_pkg::id_t   rid,
    output logic           rlast,
    // Straps
    input  mci_pkg::user_t strap_mci_soc_config_axi_user,
    input  mci_pkg::user_t strap_mcu_lsu_axi_user,
    input  mci_pkg::user_t strap_mcu_ifu_axi_user,
    input  mci_pkg::user_t strap_mcu_sram_config_axi_user,
    // Privileged request levels
    output logic           axi_mci_soc_config_req,
    output logic           axi_mcu_lsu_req,
    output logic           axi_mcu_ifu_req,
    output logic           axi_mcu_req,
    output logic           axi_mcu_sram_config_req
);

    cif_if soc_req ();
    cif_if regs_req ();
    cif_if sram_req ();

    logic soc_config_priv;

    // Full duplex AXI in, simplex request out
    axi_sub u_axi_sub (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .awid, .awuser, .awlen,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .bid,
        .arvalid, .arready, .araddr, .arid, .aruser, .arlen,
        .rvalid, .rready, .rdata, .rresp, .rid, .rlast,
        .soc_req (soc_req.request)
    );

    mci_axi_sub_decode u_decode (
        .clk, .rst_n,
        .soc_req  (soc_req.response),
        .regs_req (regs_req.request),
        .sram_req (sram_req.request),
        .soc_config_priv,
        .axi_mci_soc_config_req,
        .axi_mcu_lsu_req,
        .axi_mcu_ifu_req,
        .axi_mcu_req,
        .axi_mcu_sram_config_req,
        .strap_mci_soc_config_axi_user,
        .strap_mcu_lsu_axi_user,
        .strap_mcu_ifu_axi_user,
        .strap_mcu_sram_config_axi_user
    );

    mci_regs u_regs (
        .clk, .rst_n,
        .req (regs_req.response),
        .soc_config_priv
    );

    mcu_sram u_sram (
        .clk, .rst_n,
        .req (sram_req.response)
    );

endmodule

`default_nettype wire

// File: src/mci_regs.sv
// MCI control registers
`default_nettype none

module mci_regs (
    input  logic    clk,
    input  logic    rst_n,
    cif_if.response req,
    input  logic    soc_config_priv
);
    import mci_pkg::*;

    localparam reg_idx_t id_idx  = reg_idx_t'(reg_id_off >> 2);
    localparam reg_idx_t cfg_idx = reg_idx_t'(reg_soc_config_off >> 2);

    reg_idx_t word_idx;
    data_t    soc_config_q;
    data_t    scratch_q [2:regs_words-1];

    // Word index within the window
    assign word_idx = req.addr[$bits(reg_idx_t)+1:2];

    // Never stalls
    assign req.hold = 1'b0;

    always_comb begin
        req.rdata = '0;
        req.error = 1'b0;
        if (word_idx == id_idx) begin
            // Read only
            req.rdata = mci_id_value;
            req.error = req.write;
        end else if (word_idx == cfg_idx) begin
            req.rdata = soc_config_q;
            req.error = req.write && !soc_config_priv;
        end else begin
            req.rdata = scratch_q[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            soc_config_q <= '0;
            for (int i = 2; i < regs_words; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (req.dv && req.write) begin
            if (word_idx == cfg_idx) begin
                // Privileged writers only
                if (soc_config_priv) begin
                    soc_config_q <= merge_bytes(soc_config_q, req.wdata, req.wstrb);
                end
            end else if (word_idx != id_idx) begin
                scratch_q[word_idx] <= merge_bytes(scratch_q[word_idx], req.wdata, req.wstrb);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mcu_sram.sv
// MCU SRAM with registered read
`default_nettype none

module mcu_sram (
    input  logic    clk,
    input  logic    rst_n,
    cif_if.response req
);
    import mci_pkg::*;

    data_t     mem_q [sram_words];
    sram_idx_t idx;
    data_t     rdata_q;
    logic      rd_pend_q;
    logic      rd_start;

    assign idx = req.addr[$bits(sram_idx_t)+1:2];

    // First read cycle issues the array read
    assign rd_start = req.dv && !req.write && !rd_pend_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_start;
        end
    end

    always_ff @(posedge clk) begin
        if (req.dv && req.write) begin
            mem_q[idx] <= merge_bytes(mem_q[idx], req.wdata, req.wstrb);
        end
        if (rd_start) begin
            rdata_q <= mem_q[idx];
        end
    end

    // Stall one cycle on reads, writes go straight through
    assign req.hold  = rd_start;
    assign req.rdata = rdata_q;
    assign req.error = 1'b0;

endmodule

`default_nettype wire

// File: verif/mci_axi_sub_tb.sv
// AXI subordinate front end testbench
`default_nettype none

module mci_axi_sub_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mci_pkg::*;

    typedef enum logic [1:0] {op_wr, op_rd, op_wr_rd} op_e;

    typedef struct packed {
        op_e        op;
        addr_t      addr;
        user_t      user;
        data_t      data;
        strb_t      strb;
        id_t        id;
        resp_t      exp_resp;
        data_t      exp_rdata;
        logic [4:0] exp_priv;
    } entry_t;

    localparam int unsigned n_entries   = 16;
    localparam int unsigned cycle_limit = n_entries * 12 + 50;

    // Distinct strap users plus one unprivileged user
    localparam user_t strap_soc_cfg  = 32'h0000_5c01;
    localparam user_t strap_lsu      = 32'h0000_1150;
    localparam user_t strap_ifu      = 32'h0000_1f00;
    localparam user_t strap_sram_cfg = 32'h0000_5a30;
    localparam user_t user_plain     = 32'h0000_0bad;

    // Mask bits {sram_config, mcu, ifu, lsu, soc_config}
    localparam logic [4:0] priv_none     = 5'b00000;
    localparam logic [4:0] priv_soc_cfg  = 5'b00001;
    localparam logic [4:0] priv_lsu      = 5'b01010;
    localparam logic [4:0] priv_ifu      = 5'b01100;
    localparam logic [4:0] priv_sram_cfg = 5'b10000;

    logic clk;
    logic rst_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready, rlast;
    addr_t awaddr, araddr;
    id_t awid, arid, bid, rid;
    user_t awuser, aruser;
    logic [7:0] awlen, arlen;
    data_t wdata, rdata;
    strb_t wstrb;
    resp_t bresp, rresp;
    logic axi_mci_soc_config_req, axi_mcu_lsu_req, axi_mcu_ifu_req;
    logic axi_mcu_req, axi_mcu_sram_config_req;

    entry_t tests [n_entries];
    int unsigned n_added;
    int unsigned cycle_cnt;

    // Reference contents
    data_t model_scratch [16];
    data_t model_cfg;
    data_t model_sram [int];

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mci_axi_sub_top u_dut (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .awid, .awuser, .awlen,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .bid,
        .arvalid, .arready, .araddr, .arid, .aruser, .arlen,
        .rvalid, .rready, .rdata, .rresp, .rid, .rlast,
        .strap_mci_soc_config_axi_user  (strap_soc_cfg),
        .strap_mcu_lsu_axi_user         (strap_lsu),
        .strap_mcu_ifu_axi_user         (strap_ifu),
        .strap_mcu_sram_config_axi_user (strap_sram_cfg),
        .axi_mci_soc_config_req, .axi_mcu_lsu_req, .axi_mcu_ifu_req,
        .axi_mcu_req, .axi_mcu_sram_config_req
    );

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: no finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_no_read();
        assert (!arready) else begin
            $display("Read address accepted before the write finished at %0t", $time);
            $display("=== FAIL ===");
            $fatal(1, "read overtook write");
        end
    endtask

    task automatic add_entry(op_e op, addr_t addr, user_t user, data_t data, strb_t strb,
                             id_t id, resp_t exp_resp, data_t exp_rdata, logic [4:0] exp_priv);
        tests[n_added] = '{op, addr, user, data, strb, id, exp_resp, exp_rdata, exp_priv};
        n_added++;
    endtask

    function automatic logic [4:0] priv_now();
        return {axi_mcu_sram_config_req, axi_mcu_req, axi_mcu_ifu_req,
                axi_mcu_lsu_req, axi_mci_soc_config_req};
    endfunction

    // Strobed byte lanes take the new data
    function automatic data_t lane_merge(data_t old_w, data_t new_w, strb_t strb);
        data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic bit in_regs(addr_t a);
        return a < 32'h40;
    endfunction

    function automatic bit in_sram(addr_t a);
        return a[31:12] == 20'h00200;
    endfunction

    task automatic model_write(entry_t e);
        if (in_regs(e.addr)) begin
            // Word 0 read only and word 1 needs the soc_config strap
            if (e.addr[5:2] == 4'd1) begin
                if (e.user == strap_soc_cfg) model_cfg = lane_merge(model_cfg, e.data, e.strb);
            end else if (e.addr[5:2] != 4'd0) begin
                model_scratch[e.addr[5:2]] =
                    lane_merge(model_scratch[e.addr[5:2]], e.data, e.strb);
            end
        end else if (in_sram(e.addr)) begin
            model_sram[int'(e.addr[11:2])] =
                lane_merge(model_sram[int'(e.addr[11:2])], e.data, e.strb);
        end
    endtask

    function automatic data_t model_read(addr_t a);
        if (in_regs(a)) begin
            if (a[5:2] == 4'd0) return 32'h4d43_4900;
            if (a[5:2] == 4'd1) return model_cfg;
            return model_scratch[a[5:2]];
        end
        if (in_sram(a)) return model_sram[int'(a[11:2])];
        return '0;
    endfunction

    task automatic run_write(entry_t e, bit with_ar, inout logic [4:0] priv);
        int unsigned stall;
        awaddr = e.addr;
        awuser = e.user;
        awid   = e.id;
        wdata  = e.data;
        wstrb  = e.strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Read in the same cycle loses arbitration
        if (with_ar) begin
            araddr  = e.addr;
            aruser  = e.user;
            arid    = e.id + 8'd1;
            arvalid = 1'b1;
        end
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        // Write takes the address phase while the read waits
        if (with_ar) expect_no_read();
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            priv = priv | priv_now();
            if (with_ar) expect_no_read();
            @(negedge clk);
        end
        check_eq("bresp", 32'(bresp), 32'(e.exp_resp));
        check_eq("bid", 32'(bid), 32'(e.id));
        // Back-pressure on B
        stall = $urandom_range(3, 0);
        repeat (stall) begin
            @(negedge clk);
            if (with_ar) expect_no_read();
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic run_read(entry_t e, id_t id, inout logic [4:0] priv);
        int unsigned stall;
        araddr  = e.addr;
        aruser  = e.user;
        arid    = id;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            priv = priv | priv_now();
            @(negedge clk);
        end
        check_eq("rresp", 32'(rresp), 32'(e.exp_resp));
        check_eq("rid", 32'(rid), 32'(id));
        check_eq("rlast", 32'(rlast), 32'd1);
        check_eq("rdata", rdata, e.exp_rdata);
        check_eq("rdata vs model", rdata, model_read(e.addr));
        stall = $urandom_range(3, 0);
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic run_entry(entry_t e);
        logic [4:0] priv;
        priv = '0;
        case (e.op)
            op_wr: begin
                run_write(e, 1'b0, priv);
                model_write(e);
            end
            op_rd: run_read(e, e.id, priv);
            default: begin
                run_write(e, 1'b1, priv);
                model_write(e);
                run_read(e, e.id + 8'd1, priv);
            end
        endcase
        // Levels ORed over the whole transaction
        check_eq("privilege mask", 32'(priv), 32'(e.exp_priv));
    endtask

    initial begin
        void'($urandom(32'hbbc0));
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        awuser  = '0;
        awlen   = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        aruser  = '0;
        arlen   = '0;
        rready  = 1'b0;
        cycle_cnt = 0;
        n_added   = 0;
        model_cfg = '0;
        foreach (model_scratch[i]) model_scratch[i] = '0;

        // Identification word
        add_entry(op_rd, 32'h0, user_plain, 32'h0, 4'h0, 8'h01, resp_okay, 32'h4d43_4900, priv_none);
        add_entry(op_wr, 32'h0, strap_lsu, 32'hffff_ffff, 4'hf, 8'h02, resp_slverr, 32'h0, priv_lsu);
        add_entry(op_rd, 32'h0, strap_ifu, 32'h0, 4'h0, 8'h03, resp_okay, 32'h4d43_4900, priv_ifu);
        // Scratch with partial strobe
        add_entry(op_wr, 32'h8, user_plain, 32'h1122_3344, 4'hf, 8'h10, resp_okay, 32'h0, priv_none);
        add_entry(op_wr, 32'h8, user_plain, 32'haabb_ccdd, 4'h5, 8'h11, resp_okay, 32'h0, priv_none);
        add_entry(op_rd, 32'h8, user_plain, 32'h0, 4'h0, 8'h12, resp_okay, 32'h11bb_33dd, priv_none);
        // SRAM with partial strobe
        add_entry(op_wr, 32'h0020_0010, strap_sram_cfg, 32'hcafe_f00d, 4'hf, 8'h20, resp_okay,
                  32'h0, priv_sram_cfg);
        add_entry(op_wr, 32'h0020_0010, strap_lsu, 32'h1234_5678, 4'hc, 8'h21, resp_okay,
                  32'h0, priv_lsu);
        add_entry(op_rd, 32'h0020_0010, strap_ifu, 32'h0, 4'h0, 8'h22, resp_okay,
                  32'h1234_f00d, priv_ifu);
        // soc_config privilege
        add_entry(op_wr, 32'h4, strap_soc_cfg, 32'h0000_00a5, 4'hf, 8'h30, resp_okay, 32'h0,
                  priv_soc_cfg);
        add_entry(op_wr, 32'h4, user_plain, 32'h0000_005a, 4'hf, 8'h31, resp_slverr, 32'h0,
                  priv_none);
        add_entry(op_rd, 32'h4, user_plain, 32'h0, 4'h0, 8'h32, resp_okay, 32'h0000_00a5, priv_none);
        // Unmapped addresses including the word just past the SRAM
        add_entry(op_wr, 32'h0010_0000, user_plain, 32'h0bad_0bad, 4'hf, 8'h40, resp_slverr,
                  32'h0, priv_none);
        add_entry(op_rd, 32'h0010_0000, user_plain, 32'h0, 4'h0, 8'h41, resp_slverr, 32'h0,
                  priv_none);
        add_entry(op_rd, 32'h0020_1000, user_plain, 32'h0, 4'h0, 8'h42, resp_slverr, 32'h0,
                  priv_none);
        // Write and read together so the read sees new data
        add_entry(op_wr_rd, 32'h3c, strap_lsu, 32'h5566_7788, 4'hf, 8'h50, resp_okay,
                  32'h5566_7788, priv_lsu);

        assert (n_added == n_entries) else begin
            $display("Stimulus table holds %0d entries instead of %0d", n_added, n_entries);
            $display("=== FAIL ===");
            $fatal(1, "table size");
        end

        wait (rst_n);
        @(negedge clk);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(tests[i]);
            @(negedge clk);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over four rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
